//--- pid_macros.svh
`ifndef PID_MACROS_SVH
`define PID_MACROS_SVH

// Width of every data word in the controller, including gains and samples.
`define PID_D_WIDTH 18

// Fractional bits of the gains, so 1 << 15 is a gain of 1.0.
`define PID_Q_BITS 15

// Output saturation limits of the control value.
`define PID_LIM_MAX 4096
`define PID_LIM_MIN (-4096)

// Number of samples the measurement buffer can hold.
`define PID_FIFO_DEPTH 4

// APB byte address width. Registers sit on word boundaries.
`define PID_ADDR_WIDTH 5

`endif

//--- pid_pkg.sv
`include "pid_macros.svh"

package pid_pkg;

    // Register word index, taken from paddr[4:2].
    typedef enum logic [2:0] {
        REG_KP     = 3'd0,
        REG_KI     = 3'd1,
        REG_KD1    = 3'd2,
        REG_KD2    = 3'd3,
        REG_TARGET = 3'd4,
        REG_MEAS   = 3'd5,
        REG_OUTPUT = 3'd6,
        REG_STATUS = 3'd7
    } pid_reg_e;

    typedef enum logic [1:0] {
        APB_IDLE,
        APB_ACCESS,
        APB_WAIT_SPACE
    } apb_state_e;

    typedef struct packed {
        logic signed [`PID_D_WIDTH-1:0] kp;
        logic signed [`PID_D_WIDTH-1:0] ki;
        logic signed [`PID_D_WIDTH-1:0] kd1;
        logic signed [`PID_D_WIDTH-1:0] kd2;
    } pid_gains_t;

    typedef struct packed {
        logic signed [`PID_D_WIDTH-1:0] target;
        logic signed [`PID_D_WIDTH-1:0] measurement;
    } pid_sample_t;

    typedef struct packed {
        logic                       psel;
        logic                       penable;
        logic                       pwrite;
        logic [`PID_ADDR_WIDTH-1:0] paddr;
        logic [31:0]                pwdata;
    } apb_req_t;

endpackage

//--- pid_apb_regs.sv
`timescale 1ns/100ps
`include "pid_macros.svh"

module pid_apb_regs (
    input  logic                           i_clock,
    input  logic                           i_reset,
    input  pid_pkg::apb_req_t              i_apb,
    output logic [31:0]                    o_prdata,
    output logic                           o_pready,
    output pid_pkg::pid_gains_t            o_gains,
    output logic                           o_push,
    output pid_pkg::pid_sample_t           o_sample,
    input  logic                           i_full,
    input  logic                           i_empty,
    input  logic signed [`PID_D_WIDTH-1:0] i_control
);

    import pid_pkg::*;

    apb_state_e                     state;
    pid_reg_e                       reg_sel;
    logic signed [`PID_D_WIDTH-1:0] target;
    logic signed [`PID_D_WIDTH-1:0] wdata;
    logic [31:0]                    read_data;
    logic                           meas_write;
    logic                           access_done;

    function automatic logic [31:0] sext(input logic [`PID_D_WIDTH-1:0] value);
        return {{(32 - `PID_D_WIDTH){value[`PID_D_WIDTH-1]}}, value};
    endfunction

    assign reg_sel     = pid_reg_e'(i_apb.paddr[`PID_ADDR_WIDTH-1:2]);
    assign wdata       = i_apb.pwdata[`PID_D_WIDTH-1:0];
    assign meas_write  = i_apb.pwrite && (reg_sel == REG_MEAS);
    assign access_done = (state == APB_ACCESS) && i_apb.psel && i_apb.penable;

    // A measurement is paired with the target in force when it is written.
    assign o_push             = access_done && meas_write;
    assign o_sample.target      = target;
    assign o_sample.measurement = wdata;

    always_comb begin
        case (reg_sel)
            REG_KP:     read_data = sext(o_gains.kp);
            REG_KI:     read_data = sext(o_gains.ki);
            REG_KD1:    read_data = sext(o_gains.kd1);
            REG_KD2:    read_data = sext(o_gains.kd2);
            REG_TARGET: read_data = sext(target);
            REG_OUTPUT: read_data = sext(i_control);
            REG_STATUS: read_data = {30'b0, i_full, i_empty};
            default:    read_data = '0;
        endcase
    end

    // ########################################################################
    // Transfer FSM. Read data and pready are registered in the setup cycle.
    // ########################################################################
    always_ff @(posedge i_clock or negedge i_reset) begin
        if (!i_reset) begin
            state    <= APB_IDLE;
            o_pready <= 1'b0;
            o_prdata <= '0;
        end else begin
            case (state)
                APB_IDLE: begin
                    if (i_apb.psel && !i_apb.penable) begin
                        if (meas_write && i_full) begin
                            state <= APB_WAIT_SPACE;
                        end else begin
                            state    <= APB_ACCESS;
                            o_pready <= 1'b1;
                        end
                        if (!i_apb.pwrite) begin
                            o_prdata <= read_data;
                        end
                    end
                end
                APB_WAIT_SPACE: begin
                    if (!i_full) begin
                        state    <= APB_ACCESS;
                        o_pready <= 1'b1;
                    end
                end
                APB_ACCESS: begin
                    state    <= APB_IDLE;
                    o_pready <= 1'b0;
                end
                default: state <= APB_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clock or negedge i_reset) begin
        if (!i_reset) begin
            o_gains <= '0;
            target  <= '0;
        end else if (access_done && i_apb.pwrite) begin
            case (reg_sel)
                REG_KP:     o_gains.kp  <= wdata;
                REG_KI:     o_gains.ki  <= wdata;
                REG_KD1:    o_gains.kd1 <= wdata;
                REG_KD2:    o_gains.kd2 <= wdata;
                REG_TARGET: target      <= wdata;
                default:    ;
            endcase
        end
    end

    // The wait state must hold every push off until the buffer has room.
    a_no_push_when_full: assert property (
        @(posedge i_clock) disable iff (!i_reset) o_push |-> !i_full
    );

endmodule

//--- pid_sample_fifo.sv
`timescale 1ns/100ps
`include "pid_macros.svh"

module pid_sample_fifo #(
    parameter int DEPTH = `PID_FIFO_DEPTH
) (
    input  logic                 i_clock,
    input  logic                 i_reset,
    input  logic                 i_push,
    input  pid_pkg::pid_sample_t i_data,
    input  logic                 i_pop,
    output pid_pkg::pid_sample_t o_head,
    output logic                 o_full,
    output logic                 o_empty
);

    import pid_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    pid_sample_t      mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Show-ahead head, valid whenever the buffer holds a sample.
    assign o_head  = mem[rd_ptr];
    assign o_full  = (count == CNT_W'(DEPTH));
    assign o_empty = (count == '0);

    always_ff @(posedge i_clock) begin
        if (i_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge i_clock or negedge i_reset) begin
        if (!i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (i_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (i_push && !i_pop) begin
                count <= count + 1'b1;
            end else if (i_pop && !i_push) begin
                count <= count - 1'b1;
            end
        end
    end

    a_no_pop_when_empty: assert property (
        @(posedge i_clock) disable iff (!i_reset) i_pop |-> !o_empty
    );
    a_no_push_when_full: assert property (
        @(posedge i_clock) disable iff (!i_reset) i_push |-> !o_full
    );

endmodule

//--- pid_core.sv
`timescale 1ns/100ps
`include "pid_macros.svh"

module pid_core (
    input  logic                           i_clock,
    input  logic                           i_reset,
    input  pid_pkg::pid_gains_t            i_gains,
    input  logic                           i_empty,
    input  pid_pkg::pid_sample_t           i_head,
    output logic                           o_pop,
    output logic signed [`PID_D_WIDTH-1:0] o_control,
    output logic                           o_control_valid
);

    import pid_pkg::*;

    localparam int D = `PID_D_WIDTH;
    // Terms carry two guard bits so errors and bounds never wrap.
    localparam int W = `PID_D_WIDTH + 2;
    localparam logic signed [W-1:0] LIM_MAX = W'(`PID_LIM_MAX);
    localparam logic signed [W-1:0] LIM_MIN = W'(`PID_LIM_MIN);

    logic signed [D-1:0]   kp, ki, kd1, kd2;
    logic signed [D-1:0]   target, measurement;
    logic signed [W-1:0]   error, prev_error, error_sum, error_diff;
    logic signed [D+W-1:0] p_prod, i_prod, d_prod1, d_prod2;
    logic signed [W-1:0]   p_term, d_term, prev_d_term;
    logic signed [W-1:0]   i_acc, i_next, i_clamped, i_upper, i_lower;
    logic signed [W+1:0]   total;
    logic signed [D-1:0]   control_next;

    assign kp          = i_gains.kp;
    assign ki          = i_gains.ki;
    assign kd1         = i_gains.kd1;
    assign kd2         = i_gains.kd2;
    assign target      = i_head.target;
    assign measurement = i_head.measurement;

    // The core never stalls, so any sample at the head is taken at once.
    assign o_pop = !i_empty;

    // ########################################################################
    // One controller iteration on the sample at the head.
    // ########################################################################
    always_comb begin
        error      = W'(target) - W'(measurement);
        error_sum  = error + prev_error;
        error_diff = error - prev_error;

        p_prod  = kp * error;
        i_prod  = ki * error_sum;
        d_prod1 = kd1 * error_diff;
        d_prod2 = kd2 * prev_d_term;

        p_term = W'(p_prod >>> `PID_Q_BITS);
        i_next = i_acc + W'(i_prod >>> `PID_Q_BITS);
        d_term = W'(d_prod1 >>> `PID_Q_BITS) + W'(d_prod2 >>> `PID_Q_BITS);

        // Anti-windup. The integrator may only fill the room p leaves.
        i_upper = (LIM_MAX > p_term) ? LIM_MAX - p_term : '0;
        i_lower = (p_term > LIM_MIN) ? LIM_MIN - p_term : '0;
        if (i_next > i_upper) begin
            i_clamped = i_upper;
        end else if (i_next < i_lower) begin
            i_clamped = i_lower;
        end else begin
            i_clamped = i_next;
        end

        total = p_term + i_clamped + d_term;
        if (total > LIM_MAX) begin
            control_next = D'(LIM_MAX);
        end else if (total < LIM_MIN) begin
            control_next = D'(LIM_MIN);
        end else begin
            control_next = D'(total);
        end
    end

    always_ff @(posedge i_clock or negedge i_reset) begin
        if (!i_reset) begin
            i_acc           <= '0;
            prev_error      <= '0;
            prev_d_term     <= '0;
            o_control       <= '0;
            o_control_valid <= 1'b0;
        end else begin
            o_control_valid <= o_pop;
            if (o_pop) begin
                i_acc       <= i_clamped;
                prev_error  <= error;
                prev_d_term <= d_term;
                o_control   <= control_next;
            end
        end
    end

    a_control_in_limits: assert property (
        @(posedge i_clock) disable iff (!i_reset)
        (o_control <= `PID_LIM_MAX) && (o_control >= `PID_LIM_MIN)
    );

endmodule

//--- pid_top.sv
`timescale 1ns/100ps
`include "pid_macros.svh"

module pid_top (
    input  logic                           i_clock,
    input  logic                           i_reset,
    input  pid_pkg::apb_req_t              i_apb,
    output logic [31:0]                    o_prdata,
    output logic                           o_pready,
    output logic signed [`PID_D_WIDTH-1:0] o_control,
    output logic                           o_control_valid
);

    import pid_pkg::*;

    pid_gains_t  gains;
    pid_sample_t push_sample;
    pid_sample_t head_sample;
    logic        push;
    logic        pop;
    logic        full;
    logic        empty;

    pid_apb_regs u_apb_regs (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_apb     (i_apb),
        .o_prdata  (o_prdata),
        .o_pready  (o_pready),
        .o_gains   (gains),
        .o_push    (push),
        .o_sample  (push_sample),
        .i_full    (full),
        .i_empty   (empty),
        .i_control (o_control)
    );

    pid_sample_fifo #(
        .DEPTH (`PID_FIFO_DEPTH)
    ) u_sample_fifo (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_push  (push),
        .i_data  (push_sample),
        .i_pop   (pop),
        .o_head  (head_sample),
        .o_full  (full),
        .o_empty (empty)
    );

    pid_core u_core (
        .i_clock         (i_clock),
        .i_reset         (i_reset),
        .i_gains         (gains),
        .i_empty         (empty),
        .i_head          (head_sample),
        .o_pop           (pop),
        .o_control       (o_control),
        .o_control_valid (o_control_valid)
    );

endmodule

//--- tb_pid.sv
`timescale 1ns/100ps
`include "pid_macros.svh"

module tb_pid;

    import pid_pkg::*;

    logic                           clock;
    logic                           reset;
    apb_req_t                       apb;
    logic [31:0]                    prdata;
    logic                           pready;
    logic signed [`PID_D_WIDTH-1:0] control;
    logic                           control_valid;

    // Reference model state, kept in wide integers so nothing wraps.
    longint kp, ki, kd1, kd2, target;
    longint integ, prev_err, prev_d;

    logic signed [`PID_D_WIDTH-1:0] exp_mem [64];
    logic signed [`PID_D_WIDTH-1:0] expected_head;
    int                             exp_wr;
    int                             exp_rd;
    logic                           meas_done, meas_d1, meas_d2;
    int                             errors, errors_at_start, tests_failed;
    int unsigned                    rng_state;

    pid_top DUT (
        .i_clock         (clock),
        .i_reset         (reset),
        .i_apb           (apb),
        .o_prdata        (prdata),
        .o_pready        (pready),
        .o_control       (control),
        .o_control_valid (control_valid)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // ########################################################################
    // Reference model and stimulus helpers.
    // ########################################################################
    function automatic longint saturate(input longint value, input longint lo,
                                        input longint hi);
        if (value > hi) return hi;
        if (value < lo) return lo;
        return value;
    endfunction

    function automatic longint predict_control(input longint meas);
        longint err, p, i_next, d, upper, lower;
        err    = target - meas;
        p      = (kp * err) >>> `PID_Q_BITS;
        i_next = integ + ((ki * (err + prev_err)) >>> `PID_Q_BITS);
        d      = ((kd1 * (err - prev_err)) >>> `PID_Q_BITS)
                 + ((kd2 * prev_d) >>> `PID_Q_BITS);
        upper  = (`PID_LIM_MAX - p > 0) ? `PID_LIM_MAX - p : 0;
        lower  = (p > `PID_LIM_MIN) ? `PID_LIM_MIN - p : 0;
        integ    = saturate(i_next, lower, upper);
        prev_err = err;
        prev_d   = d;
        return saturate(p + integ + d, `PID_LIM_MIN, `PID_LIM_MAX);
    endfunction

    function automatic int next_random();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return int'(rng_state[30:16]);
    endfunction

    task automatic apb_transfer(input pid_reg_e index, input logic write,
                                input logic [31:0] wdata, output logic [31:0] rdata);
        int cycles;
        @(negedge clock);
        apb.psel    = 1'b1;
        apb.penable = 1'b0;
        apb.pwrite  = write;
        apb.paddr   = {index, 2'b00};
        apb.pwdata  = wdata;
        @(negedge clock);
        apb.penable = 1'b1;
        cycles      = 0;
        while (!pready && cycles < 16) begin
            @(negedge clock);
            cycles++;
        end
        if (!pready) begin
            $display("Timeout: pready never rose for register %s", index.name());
            errors++;
        end
        rdata = prdata;
        @(negedge clock);
        apb.psel    = 1'b0;
        apb.penable = 1'b0;
    endtask

    task automatic check_read(input pid_reg_e index, input logic [31:0] expected);
        logic [31:0] data;
        apb_transfer(index, 1'b0, '0, data);
        assert (data == expected) else begin
            $display("Fail at %0t: read of %s gave %h, expected %h",
                     $time, index.name(), data, expected);
            errors++;
        end
    endtask

    task automatic check_status();
        logic [31:0] data;
        apb_transfer(REG_STATUS, 1'b0, '0, data);
        assert (data[1:0] != 2'b11 && !data[1]) else begin
            $display("Fail at %0t: status bits %b are inconsistent", $time, data[1:0]);
            errors++;
        end
    endtask

    task automatic write_reg(input pid_reg_e index, input longint value);
        logic [31:0] unused;
        apb_transfer(index, 1'b1, 32'(value), unused);
    endtask

    task automatic set_gains(input longint p, input longint i, input longint d1,
                             input longint d2);
        write_reg(REG_KP, p);
        write_reg(REG_KI, i);
        write_reg(REG_KD1, d1);
        write_reg(REG_KD2, d2);
        kp  = p;
        ki  = i;
        kd1 = d1;
        kd2 = d2;
    endtask

    task automatic set_target(input longint value);
        write_reg(REG_TARGET, value);
        target = value;
    endtask

    // The prediction is queued before the push so the checker finds it in order.
    task automatic send_measurement(input longint meas);
        exp_mem[exp_wr % 64] = `PID_D_WIDTH'(predict_control(meas));
        exp_wr++;
        write_reg(REG_MEAS, meas);
    endtask

    task automatic wait_results();
        int cycles;
        cycles = 0;
        while (exp_rd != exp_wr && cycles < 20) begin
            @(negedge clock);
            cycles++;
        end
        if (exp_rd != exp_wr) begin
            $display("Timeout: %0d control values never arrived", exp_wr - exp_rd);
            errors++;
        end
    endtask

    task automatic drive_error(input longint err, input int count);
        repeat (count) begin
            send_measurement(target - err);
            wait_results();
        end
    endtask

    task automatic finish_test(input string name);
        if (errors == errors_at_start) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: %0d failed checks", name, errors - errors_at_start);
            tests_failed++;
        end
        errors_at_start = errors;
    endtask

    // ########################################################################
    // Checkers on the control output.
    // ########################################################################
    assign expected_head = exp_mem[exp_rd % 64];
    assign meas_done = apb.psel && apb.penable && apb.pwrite && pready
                       && (apb.paddr[`PID_ADDR_WIDTH-1:2] == REG_MEAS);

    always @(posedge clock or negedge reset) begin
        if (!reset) begin
            meas_d1 <= 1'b0;
            meas_d2 <= 1'b0;
            exp_rd  <= 0;
        end else begin
            meas_d1 <= meas_done;
            meas_d2 <= meas_d1;
            if (control_valid) begin
                exp_rd <= exp_rd + 1;
            end
        end
    end

    a_control_matches_model: assert property (
        @(posedge clock) disable iff (!reset) control_valid |-> (control == expected_head)
    ) else begin
        $display("Fail at %0t: control %0d, model expects %0d",
                 $time, $sampled(control), $sampled(expected_head));
        errors++;
    end

    a_valid_two_cycles_later: assert property (
        @(posedge clock) disable iff (!reset) control_valid == meas_d2
    ) else begin
        $display("Fail at %0t: control valid out of step with the measurement", $time);
        errors++;
    end

    initial begin
        rng_state       = 70;
        errors          = 0;
        errors_at_start = 0;
        tests_failed    = 0;
        exp_wr          = 0;
        {kp, ki, kd1, kd2, target} = '0;
        {integ, prev_err, prev_d}  = '0;
        reset = 1'b0;
        apb   = '0;
        repeat (2) @(negedge clock);
        reset = 1'b1;

        check_read(REG_KP, 32'd0);
        check_read(REG_KI, 32'd0);
        check_read(REG_KD1, 32'd0);
        check_read(REG_KD2, 32'd0);
        check_read(REG_TARGET, 32'd0);
        check_read(REG_OUTPUT, 32'd0);
        check_read(REG_STATUS, 32'h1);
        finish_test("test 1 reset values");

        // Bit 17 is the sign of every register.
        // Write bits above it are dropped.
        write_reg(REG_KP, 12345);
        check_read(REG_KP, 32'd12345);
        write_reg(REG_KI, -7);
        check_read(REG_KI, 32'hFFFF_FFF9);
        write_reg(REG_KD1, 32'h0002_0000);
        check_read(REG_KD1, 32'hFFFE_0000);
        write_reg(REG_KD2, 32'hABC1_FFFF);
        check_read(REG_KD2, 32'h0001_FFFF);
        write_reg(REG_TARGET, -100000);
        check_read(REG_TARGET, 32'(-100000));
        finish_test("test 2 register readback");

        set_gains(32768, 0, 0, 0);
        set_target(1000);
        foreach (exp_mem[k]) begin
            if (k < 5) begin
                send_measurement((k % 2 == 0) ? 1000 - 1500 * k : 1000 + 2500 * k);
                wait_results();
            end
        end
        finish_test("test 3 proportional only");

        set_gains(24576, 4096, 8192, 16384);
        set_target(2000);
        repeat (20) begin
            send_measurement(2000 + (next_random() % 1024) - 512);
            wait_results();
        end
        check_read(REG_OUTPUT, 32'(exp_mem[(exp_wr - 1) % 64]));
        finish_test("test 4 full PID sequence");

        set_gains(16384, 8192, 0, 0);
        set_target(0);
        drive_error(2000, 10);
        check_read(REG_OUTPUT, 32'(`PID_LIM_MAX));
        drive_error(-2000, 10);
        check_read(REG_OUTPUT, 32'(`PID_LIM_MIN));
        drive_error(2000, 6);
        finish_test("test 5 anti-windup");

        set_gains(32768, 0, 0, 0);
        set_target(500);
        send_measurement(100);
        set_target(-700);
        check_status();
        send_measurement(100);
        check_status();
        wait_results();
        check_status();
        finish_test("test 6 target change ordering");

        $display("tests run: 6, tests failed: %0d, failed checks: %0d",
                 tests_failed, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+.
pid_pkg.sv
pid_apb_regs.sv
pid_sample_fifo.sv
pid_core.sv
pid_top.sv
tb_pid.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module tb_pid --Mdir obj_dir -o tb_pid_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_pid_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" "$LOG"; then
    exit 1
fi
exit 0
